/* verif/soc_cases.txt */
# op addr_or_sel data strb expected; write/read use the bus address, pads select
# 0 out 1 outenb 2 pullupb 3 pulldownb; pads/irq data bits 15:0 gpio_in 16 xtal 17 pll 18 trap 19 pin 20 spi
write 00000100 11223344 f 00000000
write 00000100 aabbccdd 5 00000000
read  00000100 00000000 0 11bb33dd
write 0000fffc 0badf00d f 00000000
write 0000fffc 00c0ffee 6 00000000
read  0000fffc 00000000 0 0bc0ff0d
read  03000004 00000000 0 0000ffff
write 03000004 0000a5c3 1 00000000
read  03000004 00000000 0 0000ffc3
write 03000008 12345678 3 00000000
read  03000008 00000000 0 00005678
write 0300000c 9abcdef0 2 00000000
read  0300000c 00000000 0 0000de00
read  03000018 00000000 0 000000a5
read  03000024 00000000 0 00000456
read  03000028 00000000 0 00000011
read  0300002c 00000000 0 00000002
read  03000030 00000000 0 00000001
read  03000050 00000000 0 00000000
write 03000034 00000002 1 00000000
pads  00000000 00010000 0 00000040
pads  00000001 00010000 0 0000ff03
pads  00000002 00010000 0 000056f8
pads  00000003 00010000 0 0000dee0
write 03000038 00000001 1 00000000
write 0300003c 00000003 1 00000000
pads  00000000 0006beef 0 00002100
pads  00000001 0006beef 0 0000c003
pads  00000002 0006beef 0 00007ff8
pads  00000003 0006beef 0 0000ffe0
read  03000000 00000000 0 2100beef
write 03000038 00000002 1 00000000
pads  00000000 00060000 0 00002200
write 03000040 00000001 1 00000000
write 03000044 00000001 1 00000000
irq   00000000 00000001 0 00000080
irq   00000000 00000008 0 00000100
write 03000040 00000002 1 00000000
write 03000044 00000003 1 00000000
irq   00000000 00000022 0 00000180
irq   00000000 0000001d 0 00000000
irq   00000000 00180000 0 00000060
write 03000040 00000000 1 00000000
irq   00000000 0018ffff 0 00000160

/* vlog.f */
hdl/soc_pkg.sv
hdl/mem_decoder.sv
hdl/sysctl_regs.sv
hdl/gpio_pad_mux.sv
hdl/irq_router.sv
hdl/soc_sysctl_top.sv
verif/soc_checker.sv
verif/soc_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f vlog.f &&
./obj_dir/Vsoc_tb | tee /dev/stderr | grep -qF "Result: PASSED" || exit 1

/* verif/soc_tb.sv */
// testbench for soc_sysctl_top, replays the operations of verif/soc_cases.txt against a model SRAM
module soc_tb;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic                       mem_valid_i;
  soc_pkg::soc_addr_u         mem_addr_i;
  logic [31:0]                mem_wdata_i;
  logic [3:0]                 mem_wstrb_i;
  logic                       mem_ready_o;
  logic [31:0]                mem_rdata_o;
  logic [3:0]                 ram_wstrb_o;
  logic [soc_pkg::RAM_AW-1:0] ram_addr_o;
  logic [31:0]                ram_wdata_o;
  logic [31:0]                ram_rdata_i;
  logic                       xtal_in_i;
  logic                       clk_pll_i;
  logic                       trap_i;
  logic                       clk_ext_sel_i;
  logic [7:0]                 hk_config_i;
  logic [11:0]                hk_mfgr_i;
  logic [7:0]                 hk_prod_i;
  logic [3:0]                 hk_mask_i;
  logic [soc_pkg::GPIO_W-1:0] gpio_in_i;
  logic [soc_pkg::GPIO_W-1:0] gpio_out_o;
  logic [soc_pkg::GPIO_W-1:0] gpio_outenb_o;
  logic [soc_pkg::GPIO_W-1:0] gpio_pullupb_o;
  logic [soc_pkg::GPIO_W-1:0] gpio_pulldownb_o;
  logic                       irq_pin_i;
  logic                       irq_spi_i;
  logic [soc_pkg::IRQ_W-1:0]  irq_o;

  logic [31:0] sram [soc_pkg::MEM_WORDS];
  string       case_op[$];
  logic [31:0] case_addr[$];
  logic [31:0] case_data[$];
  logic [31:0] case_strb[$];
  logic [31:0] case_exp[$];
  logic        cases_loaded = 1'b0;
  int          value_errs = 0;
  int          proto_errs = 0;

  soc_sysctl_top dut_i (.*);

  always #20 clk_i = ~clk_i;

  // sram model, byte writes at the clock edge, combinational read
  assign ram_rdata_i = sram[ram_addr_o];
  always @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb_o[b]) begin
        sram[ram_addr_o][8*b +: 8] <= ram_wdata_o[8*b +: 8];
      end
    end
  end

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_pads(input string name, input logic [soc_pkg::GPIO_W-1:0] exp,
                            input logic [soc_pkg::GPIO_W-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_irq(input string name, input logic [soc_pkg::IRQ_W-1:0] exp,
                           input logic [soc_pkg::IRQ_W-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    fd = $fopen("verif/soc_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      proto_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %h %h %h %h", op, a, d, s, e);
      if (n == 5 && op != "#") begin
        case_op.push_back(op);
        case_addr.push_back(a);
        case_data.push_back(d);
        case_strb.push_back(s);
        case_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // gpio_in in bits 15:0, then xtal, pll clock, trap, irq pin, irq spi
  task automatic drive_inputs(input logic [31:0] w);
    gpio_in_i = w[15:0];
    xtal_in_i = w[16];
    clk_pll_i = w[17];
    trap_i    = w[18];
    irq_pin_i = w[19];
    irq_spi_i = w[20];
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int   waited;
    logic got;
    waited = 0;
    got = 1'b0;
    rdata = '0;
    mem_addr_i.raw = addr;
    mem_wdata_i = data;
    mem_wstrb_i = strb;
    mem_valid_i = 1'b1;
    while (!got && waited < 4) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (mem_ready_o) begin
        got = 1'b1;
        rdata = mem_rdata_o;
      end
    end
    if (!got) begin
      $display("no ready within 4 cycles for the access to %h", addr);
      proto_errs++;
    end else if (waited != 1) begin
      $display("ready for the access to %h came after %0d cycles, not 1", addr, waited);
      proto_errs++;
    end
    @(posedge clk_i);
    #2;
    mem_valid_i = 1'b0;
    mem_wstrb_i = 4'h0;
  endtask

  task automatic run_case(input int i);
    logic [31:0] rdata;
    if (case_op[i] == "write" || case_op[i] == "read") begin
      bus_access(case_addr[i], case_data[i], case_strb[i][3:0], rdata);
      if (case_op[i] == "read") begin
        check_word("mem_rdata_o", case_exp[i], rdata);
      end
    end else begin
      drive_inputs(case_data[i]);
      // sampled while clk_i is high, so a core clock on pad 9 reads 1
      #10;
      if (case_op[i] == "pads") begin
        case (case_addr[i][1:0])
          2'd0: check_pads("gpio_out_o", case_exp[i][15:0], gpio_out_o);
          2'd1: check_pads("gpio_outenb_o", case_exp[i][15:0], gpio_outenb_o);
          2'd2: check_pads("gpio_pullupb_o", case_exp[i][15:0], gpio_pullupb_o);
          default: check_pads("gpio_pulldownb_o", case_exp[i][15:0], gpio_pulldownb_o);
        endcase
      end else if (case_op[i] == "irq") begin
        check_irq("irq_o", case_exp[i], irq_o);
      end else begin
        $display("unknown operation %s in case %0d", case_op[i], i);
        proto_errs++;
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic check_reset_state();
    check_pads("gpio_outenb_o", '1, gpio_outenb_o);
    check_pads("gpio_out_o", '0, gpio_out_o);
    check_word("mem_ready_o", 32'h0, 32'(mem_ready_o));
  endtask

  initial begin
    rst_n_i = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i.raw = 32'h0;
    mem_wdata_i = 32'h0;
    mem_wstrb_i = 4'h0;
    clk_ext_sel_i = 1'b1;
    hk_config_i = 8'ha5;
    hk_mfgr_i = 12'h456;
    hk_prod_i = 8'h11;
    hk_mask_i = 4'h2;
    drive_inputs(32'h0);
    load_cases();
    cases_loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    #2;
    check_reset_state();
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    check_reset_state();
    #1;
    foreach (case_op[i]) begin
      run_case(i);
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errs, proto_errs, dut_i.u_mem_decoder.u_checker.assert_errs);
    if (value_errs == 0 && proto_errs == 0 && case_op.size() > 0 &&
        dut_i.u_mem_decoder.u_checker.assert_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // 10 cycles per case plus reset and a small margin
  initial begin
    wait (cases_loaded);
    #((case_op.size() * 10 + 12) * 40);
    $display("watchdog expired before all cases ran");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* verif/soc_checker.sv */
// bus protocol assertions, bound into mem_decoder
module soc_checker (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       mem_valid_i,
  input logic       mem_ready_o,
  input logic [3:0] ram_wstrb_o
);

  int assert_errs = 0;

  // ready is a single-cycle pulse
  ready_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_o |=> !mem_ready_o)
    else begin
      assert_errs++;
      $error("mem_ready_o held high for two cycles");
    end

  ready_needs_valid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_ready_o) |-> mem_valid_i)
    else begin
      assert_errs++;
      $error("mem_ready_o rose without mem_valid_i");
    end

  // no sram write strobe outside a bus access
  wstrb_needs_valid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_wstrb_o != 4'h0) |-> mem_valid_i)
    else begin
      assert_errs++;
      $error("ram_wstrb_o active without mem_valid_i");
    end

endmodule

bind mem_decoder soc_checker u_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .mem_valid_i (mem_valid_i),
  .mem_ready_o (mem_ready_o),
  .ram_wstrb_o (ram_wstrb_o)
);

/* hdl/soc_sysctl_top.sv */
// system-control fabric top: bus decode, register bank, pad routing and interrupt vector
module soc_sysctl_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       mem_valid_i,
  input  soc_pkg::soc_addr_u         mem_addr_i,
  input  logic [31:0]                mem_wdata_i,
  input  logic [3:0]                 mem_wstrb_i,
  output logic                       mem_ready_o,
  output logic [31:0]                mem_rdata_o,
  output logic [3:0]                 ram_wstrb_o,
  output logic [soc_pkg::RAM_AW-1:0] ram_addr_o,
  output logic [31:0]                ram_wdata_o,
  input  logic [31:0]                ram_rdata_i,
  input  logic                       xtal_in_i,
  input  logic                       clk_pll_i,
  input  logic                       trap_i,
  input  logic                       clk_ext_sel_i,
  input  logic [7:0]                 hk_config_i,
  input  logic [11:0]                hk_mfgr_i,
  input  logic [7:0]                 hk_prod_i,
  input  logic [3:0]                 hk_mask_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_outenb_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_pullupb_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_pulldownb_o,
  input  logic                       irq_pin_i,
  input  logic                       irq_spi_i,
  output logic [soc_pkg::IRQ_W-1:0]  irq_o
);

  logic                       io_sel;
  logic                       io_ready;
  logic [31:0]                io_rdata;
  logic [soc_pkg::GPIO_W-1:0] gpio_q;
  logic [soc_pkg::GPIO_W-1:0] oeb_q;
  logic [soc_pkg::GPIO_W-1:0] pu_q;
  logic [soc_pkg::GPIO_W-1:0] pd_q;
  logic [soc_pkg::DEST_W-1:0] xtal_dest;
  logic [soc_pkg::DEST_W-1:0] pll_dest;
  logic [soc_pkg::DEST_W-1:0] trap_dest;
  logic [soc_pkg::DEST_W-1:0] irq7_src;
  logic [soc_pkg::DEST_W-1:0] irq8_src;

  assign ram_wdata_o = mem_wdata_i;

  mem_decoder u_mem_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wstrb_i (mem_wstrb_i),
    .ram_rdata_i (ram_rdata_i),
    .io_ready_i  (io_ready),
    .io_rdata_i  (io_rdata),
    .io_sel_o    (io_sel),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_addr_o  (ram_addr_o),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o)
  );

  sysctl_regs u_sysctl_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .io_sel_i      (io_sel),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .gpio_out_i    (gpio_out_o),
    .gpio_in_i     (gpio_in_i),
    .hk_config_i   (hk_config_i),
    .hk_mfgr_i     (hk_mfgr_i),
    .hk_prod_i     (hk_prod_i),
    .hk_mask_i     (hk_mask_i),
    .clk_ext_sel_i (clk_ext_sel_i),
    .io_ready_o    (io_ready),
    .io_rdata_o    (io_rdata),
    .gpio_q_o      (gpio_q),
    .oeb_q_o       (oeb_q),
    .pu_q_o        (pu_q),
    .pd_q_o        (pd_q),
    .xtal_dest_o   (xtal_dest),
    .pll_dest_o    (pll_dest),
    .trap_dest_o   (trap_dest),
    .irq7_src_o    (irq7_src),
    .irq8_src_o    (irq8_src)
  );

  gpio_pad_mux u_gpio_pad_mux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .trap_i           (trap_i),
    .gpio_q_i         (gpio_q),
    .oeb_q_i          (oeb_q),
    .pu_q_i           (pu_q),
    .pd_q_i           (pd_q),
    .xtal_dest_i      (xtal_dest),
    .pll_dest_i       (pll_dest),
    .trap_dest_i      (trap_dest),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o)
  );

  irq_router u_irq_router (
    .gpio_in_i  (gpio_in_i),
    .irq7_src_i (irq7_src),
    .irq8_src_i (irq8_src),
    .irq_pin_i  (irq_pin_i),
    .irq_spi_i  (irq_spi_i),
    .irq_o      (irq_o)
  );

endmodule

/* hdl/irq_router.sv */
// picks gpio interrupt sources for irq 7/8 and builds the interrupt vector
module irq_router (
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  input  logic [soc_pkg::DEST_W-1:0] irq7_src_i,
  input  logic [soc_pkg::DEST_W-1:0] irq8_src_i,
  input  logic                       irq_pin_i,
  input  logic                       irq_spi_i,
  output logic [soc_pkg::IRQ_W-1:0]  irq_o
);

  // source 0 disables, 1..3 picks one of three pins
  function automatic logic pick_src(
    input logic [soc_pkg::DEST_W-1:0] src,
    input logic [2:0]                 pins
  );
    logic res;
    res = 1'b0;
    if (src != '0) begin
      res = pins[src - 1'b1];
    end
    return res;
  endfunction

  always_comb begin
    irq_o                       = '0;
    irq_o[soc_pkg::IRQ_PIN_BIT] = irq_pin_i;
    irq_o[soc_pkg::IRQ_SPI_BIT] = irq_spi_i;
    irq_o[soc_pkg::IRQ7_BIT]    = pick_src(irq7_src_i, gpio_in_i[2:0]);
    irq_o[soc_pkg::IRQ8_BIT]    = pick_src(irq8_src_i, gpio_in_i[5:3]);
  end

endmodule

/* hdl/gpio_pad_mux.sv */
// pad routing: puts crystal, pll, core clock and trap on pads 5-13 and forces pad controls
module gpio_pad_mux (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       xtal_in_i,
  input  logic                       clk_pll_i,
  input  logic                       trap_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_q_i,
  input  logic [soc_pkg::GPIO_W-1:0] oeb_q_i,
  input  logic [soc_pkg::GPIO_W-1:0] pu_q_i,
  input  logic [soc_pkg::GPIO_W-1:0] pd_q_i,
  input  logic [soc_pkg::DEST_W-1:0] xtal_dest_i,
  input  logic [soc_pkg::DEST_W-1:0] pll_dest_i,
  input  logic [soc_pkg::DEST_W-1:0] trap_dest_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_outenb_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_pullupb_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_pulldownb_o
);

  logic [soc_pkg::GPIO_W-1:0] pad_oeb;

  always_comb begin
    gpio_out_o       = gpio_q_i;
    pad_oeb          = oeb_q_i;
    gpio_pullupb_o   = pu_q_i;
    gpio_pulldownb_o = pd_q_i;

    // crystal group, pads 5..7
    if (xtal_dest_i != '0) begin
      pad_oeb[7:5]          = '0;
      gpio_pullupb_o[7:5]   = '1;
      gpio_pulldownb_o[7:5] = '1;
      gpio_out_o[4 + xtal_dest_i] = xtal_in_i;
    end

    // clock group, pads 8..10
    if (pll_dest_i != '0) begin
      pad_oeb[10:8]          = '0;
      gpio_pullupb_o[10:8]   = '1;
      gpio_pulldownb_o[10:8] = '1;
      if (pll_dest_i == 2'd1) begin
        gpio_out_o[8] = clk_pll_i;
      end else if (pll_dest_i == 2'd2) begin
        gpio_out_o[9] = clk_i;
      end
    end

    // trap group, pads 11..13
    if (trap_dest_i != '0) begin
      pad_oeb[13:11]          = '0;
      gpio_pullupb_o[13:11]   = '1;
      gpio_pulldownb_o[13:11] = '1;
      gpio_out_o[10 + trap_dest_i] = trap_i;
    end
  end

  // outputs stay tri-stated while reset is held
  assign gpio_outenb_o = pad_oeb | {soc_pkg::GPIO_W{~rst_n_i}};

endmodule

/* hdl/sysctl_regs.sv */
// system-control register bank at 0x0300_00xx with byte-strobe writes and registered readback
module sysctl_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      io_sel_i,
  input  soc_pkg::soc_addr_u        mem_addr_i,
  input  logic [31:0]               mem_wdata_i,
  input  logic [3:0]                mem_wstrb_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_out_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  input  logic [7:0]                hk_config_i,
  input  logic [11:0]               hk_mfgr_i,
  input  logic [7:0]                hk_prod_i,
  input  logic [3:0]                hk_mask_i,
  input  logic                      clk_ext_sel_i,
  output logic                      io_ready_o,
  output logic [31:0]               io_rdata_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_q_o,
  output logic [soc_pkg::GPIO_W-1:0] oeb_q_o,
  output logic [soc_pkg::GPIO_W-1:0] pu_q_o,
  output logic [soc_pkg::GPIO_W-1:0] pd_q_o,
  output logic [soc_pkg::DEST_W-1:0] xtal_dest_o,
  output logic [soc_pkg::DEST_W-1:0] pll_dest_o,
  output logic [soc_pkg::DEST_W-1:0] trap_dest_o,
  output logic [soc_pkg::DEST_W-1:0] irq7_src_o,
  output logic [soc_pkg::DEST_W-1:0] irq8_src_o
);

  logic                       hit;
  logic                       ready_q;
  logic [31:0]                rdata_q;
  logic [soc_pkg::DEST_W-1:0] wfield;

  // byte 0 and byte 1 of a pad register, each under its own strobe
  function automatic logic [soc_pkg::GPIO_W-1:0] merge_pads(
    input logic [soc_pkg::GPIO_W-1:0] old_val,
    input logic [31:0]                wdata,
    input logic [3:0]                 wstrb
  );
    logic [soc_pkg::GPIO_W-1:0] res;
    res = old_val;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  // one access per ready pulse, never twice in a row
  assign hit    = io_sel_i && !ready_q && (mem_addr_i.io.page == soc_pkg::IO_PAGE);
  assign wfield = mem_wdata_i[soc_pkg::DEST_W-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q     <= 1'b0;
      gpio_q_o    <= '0;
      oeb_q_o     <= '1;
      pu_q_o      <= '0;
      pd_q_o      <= '0;
      xtal_dest_o <= '0;
      pll_dest_o  <= '0;
      trap_dest_o <= '0;
      irq7_src_o  <= '0;
      irq8_src_o  <= '0;
    end else begin
      ready_q <= hit;
      if (hit) begin
        case (mem_addr_i.io.offset)
          soc_pkg::GPIO_DATA: gpio_q_o <= merge_pads(gpio_q_o, mem_wdata_i, mem_wstrb_i);
          soc_pkg::GPIO_OEB:  oeb_q_o  <= merge_pads(oeb_q_o, mem_wdata_i, mem_wstrb_i);
          soc_pkg::GPIO_PU:   pu_q_o   <= merge_pads(pu_q_o, mem_wdata_i, mem_wstrb_i);
          soc_pkg::GPIO_PD:   pd_q_o   <= merge_pads(pd_q_o, mem_wdata_i, mem_wstrb_i);
          soc_pkg::XTAL_DEST: begin
            if (mem_wstrb_i[0]) xtal_dest_o <= wfield;
          end
          soc_pkg::PLL_DEST: begin
            if (mem_wstrb_i[0]) pll_dest_o <= wfield;
          end
          soc_pkg::TRAP_DEST: begin
            if (mem_wstrb_i[0]) trap_dest_o <= wfield;
          end
          soc_pkg::IRQ7_SRC: begin
            if (mem_wstrb_i[0]) irq7_src_o <= wfield;
          end
          soc_pkg::IRQ8_SRC: begin
            if (mem_wstrb_i[0]) irq8_src_o <= wfield;
          end
          default: ;
        endcase
      end
    end
  end

  // readback sampled before the write lands
  always_ff @(posedge clk_i) begin
    if (hit) begin
      case (mem_addr_i.io.offset)
        soc_pkg::GPIO_DATA: rdata_q <= {gpio_out_i, gpio_in_i};
        soc_pkg::GPIO_OEB:  rdata_q <= 32'(oeb_q_o);
        soc_pkg::GPIO_PU:   rdata_q <= 32'(pu_q_o);
        soc_pkg::GPIO_PD:   rdata_q <= 32'(pd_q_o);
        soc_pkg::HK_CONFIG: rdata_q <= 32'(hk_config_i);
        soc_pkg::HK_MFGR:   rdata_q <= 32'(hk_mfgr_i);
        soc_pkg::HK_PROD:   rdata_q <= 32'(hk_prod_i);
        soc_pkg::HK_MASK:   rdata_q <= 32'(hk_mask_i);
        soc_pkg::CLK_EXT:   rdata_q <= 32'(clk_ext_sel_i);
        soc_pkg::XTAL_DEST: rdata_q <= 32'(xtal_dest_o);
        soc_pkg::PLL_DEST:  rdata_q <= 32'(pll_dest_o);
        soc_pkg::TRAP_DEST: rdata_q <= 32'(trap_dest_o);
        soc_pkg::IRQ7_SRC:  rdata_q <= 32'(irq7_src_o);
        soc_pkg::IRQ8_SRC:  rdata_q <= 32'(irq8_src_o);
        default:            rdata_q <= 32'h0000_0000;
      endcase
    end
  end

  assign io_ready_o = ready_q;
  assign io_rdata_o = rdata_q;

endmodule

/* hdl/mem_decoder.sv */
// bus region decode, SRAM strobes with registered ready, and final ready/read-data mux
module mem_decoder (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      mem_valid_i,
  input  soc_pkg::soc_addr_u        mem_addr_i,
  input  logic [3:0]                mem_wstrb_i,
  input  logic [31:0]               ram_rdata_i,
  input  logic                      io_ready_i,
  input  logic [31:0]               io_rdata_i,
  output logic                      io_sel_o,
  output logic [3:0]                ram_wstrb_o,
  output logic [soc_pkg::RAM_AW-1:0] ram_addr_o,
  output logic                      mem_ready_o,
  output logic [31:0]               mem_rdata_o
);

  logic ram_range;
  logic ram_ready_q;
  logic io_done;

  // sram occupies the bottom 4*MEM_WORDS bytes
  assign ram_range = mem_valid_i && !mem_ready_o &&
                     (mem_addr_i.raw < 32'(4 * soc_pkg::MEM_WORDS));

  assign ram_wstrb_o = ram_range ? mem_wstrb_i : 4'h0;
  assign ram_addr_o  = mem_addr_i.raw[soc_pkg::RAM_AW+1:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= ram_range;
    end
  end

  // register page lives in region 0x03
  assign io_sel_o = mem_valid_i && (mem_addr_i.io.region == soc_pkg::IO_REGION);
  assign io_done  = io_sel_o && io_ready_i;

  assign mem_ready_o = io_done || ram_ready_q;

  // register data wins over sram data
  always_comb begin
    if (io_done) begin
      mem_rdata_o = io_rdata_i;
    end else if (ram_ready_q) begin
      mem_rdata_o = ram_rdata_i;
    end else begin
      mem_rdata_o = 32'h0000_0000;
    end
  end

endmodule

/* hdl/soc_pkg.sv */
// shared address map, register offsets and widths for the system-control fabric
package soc_pkg;

  // on-chip SRAM
  localparam int MEM_WORDS = 16384;
  localparam int RAM_AW    = 14;

  // system-control register page 0x0300_00xx
  localparam logic [7:0]  IO_REGION = 8'h03;
  localparam logic [15:0] IO_PAGE   = 16'h0000;

  // pad count, routing field width, interrupt vector width
  localparam int GPIO_W = 16;
  localparam int DEST_W = 2;
  localparam int IRQ_W  = 32;

  // register offsets inside the page
  localparam logic [7:0] GPIO_DATA = 8'h00;
  localparam logic [7:0] GPIO_OEB  = 8'h04;
  localparam logic [7:0] GPIO_PU   = 8'h08;
  localparam logic [7:0] GPIO_PD   = 8'h0c;
  localparam logic [7:0] HK_CONFIG = 8'h18;
  localparam logic [7:0] HK_MFGR   = 8'h24;
  localparam logic [7:0] HK_PROD   = 8'h28;
  localparam logic [7:0] HK_MASK   = 8'h2c;
  localparam logic [7:0] CLK_EXT   = 8'h30;
  localparam logic [7:0] XTAL_DEST = 8'h34;
  localparam logic [7:0] PLL_DEST  = 8'h38;
  localparam logic [7:0] TRAP_DEST = 8'h3c;
  localparam logic [7:0] IRQ7_SRC  = 8'h40;
  localparam logic [7:0] IRQ8_SRC  = 8'h44;

  // interrupt bit positions
  localparam int IRQ_PIN_BIT = 5;
  localparam int IRQ_SPI_BIT = 6;
  localparam int IRQ7_BIT    = 7;
  localparam int IRQ8_BIT    = 8;

  // bus address, flat or split into region/page/offset
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0]  region;
      logic [15:0] page;
      logic [7:0]  offset;
    } io;
  } soc_addr_u;

endpackage
